// File: dv/operand_read_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvfwd_config.svh"

module operand_read_tb;

    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 1500;
    localparam int MAX_CYCLES    = 2000 + RESET_CYCLES;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [`RV_REG_ADDR_W-1:0]  rs1_addr;
    logic [`RV_REG_ADDR_W-1:0]  rs2_addr;
    logic [`RV_REG_ADDR_W-1:0]  ex_rd;
    logic                       ex_wen;
    logic [`RV_XLEN-1:0]        ex_result;
    rvfwd_pkg::ext_mode_e       ex_ext;
    logic [`RV_XLEN-1:0]        mem_result;
    logic [`RV_XLEN-1:0]        wb_result;
    logic [`RV_XLEN-1:0]        rs1_data;
    logic [`RV_XLEN-1:0]        rs2_data;

    // reference pipeline state
    logic [`RV_XLEN-1:0]        m_regs [`RV_REG_COUNT];
    logic [`RV_REG_ADDR_W-1:0]  m_mem_rd;
    logic [`RV_REG_ADDR_W-1:0]  m_wb_rd;
    logic                       m_mem_wen;
    logic                       m_wb_wen;

    integer      seed = 32'h483f;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    logic [31:0] r;
    int          n;

    operand_read_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .ex_rd     (ex_rd),
        .ex_wen    (ex_wen),
        .ex_result (ex_result),
        .ex_ext    (ex_ext),
        .mem_result(mem_result),
        .wb_result (wb_result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

    always #5 clk = ~clk;

    // wb writes land at the edge, then destinations shift one stage
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                m_regs[i] <= '0;
            end
            m_mem_rd  <= '0;
            m_mem_wen <= 1'b0;
            m_wb_rd   <= '0;
            m_wb_wen  <= 1'b0;
        end else begin
            if (m_wb_wen && (m_wb_rd != '0)) begin
                m_regs[m_wb_rd] <= wb_result;
            end
            m_mem_rd  <= ex_rd;
            m_mem_wen <= ex_wen;
            m_wb_rd   <= m_mem_rd;
            m_wb_wen  <= m_mem_wen;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
            $display("checks %0d, errors %0d, timeouts 1", checks, errors);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [`RV_XLEN-1:0] extend_ex(
        input logic [`RV_XLEN-1:0] v,
        input rvfwd_pkg::ext_mode_e mode
    );
        logic [`RV_XLEN-1:0] res;
        res = v;
        if (mode == rvfwd_pkg::EXT_WORD_S) begin
            res = `RV_XLEN'($signed(v[31:0]));
        end else if (mode == rvfwd_pkg::EXT_WORD_Z) begin
            res = `RV_XLEN'(v[31:0]);
        end else if (mode == rvfwd_pkg::EXT_HALF_S) begin
            res = `RV_XLEN'($signed(v[15:0]));
        end
        return res;
    endfunction

    // newest producer first, x0 always zero
    function automatic logic [`RV_XLEN-1:0] expected_operand(
        input logic [`RV_REG_ADDR_W-1:0] addr
    );
        logic [`RV_XLEN-1:0] res;
        if (addr == '0) begin
            res = '0;
        end else if (ex_wen && (ex_rd == addr)) begin
            res = extend_ex(ex_result, ex_ext);
        end else if (m_mem_wen && (m_mem_rd == addr)) begin
            res = mem_result;
        end else if (m_wb_wen && (m_wb_rd == addr)) begin
            res = wb_result;
        end else begin
            res = m_regs[addr];
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [`RV_XLEN-1:0] exp_v,
                             input logic [`RV_XLEN-1:0] act_v);
        checks = checks + 1;
        if (exp_v !== act_v) begin
            $display("mismatch %s expected %h actual %h", name, exp_v, act_v);
            errors = errors + 1;
        end
    endtask

    // one pipeline cycle: drive on the falling edge, check once settled
    task automatic run_cycle(
        input logic [`RV_REG_ADDR_W-1:0] a1,
        input logic [`RV_REG_ADDR_W-1:0] a2,
        input logic [`RV_REG_ADDR_W-1:0] rd,
        input logic                      wen,
        input logic [1:0]                ext,
        input logic [`RV_XLEN-1:0]       exr,
        input logic [`RV_XLEN-1:0]       memr,
        input logic [`RV_XLEN-1:0]       wbr
    );
        @(negedge clk);
        rs1_addr   = a1;
        rs2_addr   = a2;
        ex_rd      = rd;
        ex_wen     = wen;
        ex_ext     = rvfwd_pkg::ext_mode_e'(ext);
        ex_result  = exr;
        mem_result = memr;
        wb_result  = wbr;
        #1;
        check_val("rs1_data", expected_operand(rs1_addr), rs1_data);
        check_val("rs2_data", expected_operand(rs2_addr), rs2_data);
    endtask

    initial begin
        rst_n      = 1'b0;
        rs1_addr   = '0;
        rs2_addr   = '0;
        ex_rd      = '0;
        ex_wen     = 1'b0;
        ex_ext     = rvfwd_pkg::EXT_NONE;
        ex_result  = '0;
        mem_result = '0;
        wb_result  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // every register reads zero out of reset
        for (n = 0; n < `RV_REG_COUNT; n++) begin
            run_cycle(5'(n), 5'(`RV_REG_COUNT - 1 - n), 5'd0, 1'b0, 2'd0,
                      64'h1111, 64'h2222, 64'h3333);
        end

        // ext modes, sign bits set then clear
        for (n = 0; n < 4; n++) begin
            run_cycle(5'd5, 5'd6, 5'd5, 1'b1, 2'(n), 64'h1234_5678_8000_8001,
                      64'haaaa, 64'hbbbb);
            run_cycle(5'd5, 5'd6, 5'd5, 1'b1, 2'(n), 64'hfedc_ba98_7fff_7ffe,
                      64'haaaa, 64'hbbbb);
        end

        // x9 in ex, mem and wb at once, then mem and wb only, then rf
        run_cycle(5'd9, 5'd0, 5'd9, 1'b1, 2'd0, 64'h91, 64'h92, 64'h93);
        run_cycle(5'd9, 5'd0, 5'd9, 1'b1, 2'd0, 64'ha1, 64'ha2, 64'ha3);
        run_cycle(5'd9, 5'd9, 5'd9, 1'b1, 2'd1, 64'hb1, 64'hb2, 64'hb3);
        run_cycle(5'd9, 5'd3, 5'd0, 1'b0, 2'd0, 64'hc1, 64'hc2, 64'hc3);
        repeat (4) run_cycle(5'd9, 5'd0, 5'd0, 1'b0, 2'd0, 64'hd1, 64'hd2, 64'hd3);

        for (n = 0; n < RANDOM_CYCLES; n++) begin
            r = $random(seed);
            run_cycle({2'b00, r[2:0]}, {2'b00, r[5:3]}, {2'b00, r[8:6]}, r[9], r[11:10],
                      {$random(seed), $random(seed)}, {$random(seed), $random(seed)},
                      {$random(seed), $random(seed)});
        end

        $display("checks %0d, errors %0d, timeouts 0", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: include/rvfwd_config.svh
`ifndef RVFWD_CONFIG_SVH
`define RVFWD_CONFIG_SVH

// register address width
`define RV_REG_ADDR_W 5

// data width
`define RV_XLEN 64

// number of integer registers
`define RV_REG_COUNT 32

`endif

// File: run.sh
#!/bin/sh
# compile and run the operand read testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

if ! verilator --binary --timing --assert -f verilog.f \
        --top-module operand_read_tb --Mdir "$BUILD_DIR" -o operand_read_tb; then
    echo "compile failed"
    exit 1
fi

if ! "$BUILD_DIR/operand_read_tb" > "$SIM_LOG" 2>&1; then
    cat "$SIM_LOG"
    echo "simulation exited with an error"
    exit 1
fi

cat "$SIM_LOG"

if grep -qx "RESULT: PASS" "$SIM_LOG"; then
    exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

// File: src/hazard_track.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvfwd_config.svh"

module hazard_track (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`RV_REG_ADDR_W-1:0]  rs1_addr,
    input  wire  [`RV_REG_ADDR_W-1:0]  rs2_addr,
    input  wire  [`RV_REG_ADDR_W-1:0]  ex_rd,
    input  wire                        ex_wen,
    input  wire  [`RV_XLEN-1:0]        wb_result,
    output rvfwd_pkg::fwd_src_e        rs1_src,
    output rvfwd_pkg::fwd_src_e        rs2_src,
    output logic                       rf_we,
    output logic [`RV_REG_ADDR_W-1:0]  rf_waddr,
    output logic [`RV_XLEN-1:0]        rf_wdata
);

    logic [`RV_REG_ADDR_W-1:0] mem_rd;
    logic [`RV_REG_ADDR_W-1:0] wb_rd;
    logic                      mem_wen;
    logic                      wb_wen;

    // destination shifts ex -> mem -> wb, one stage per clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rd  <= '0;
            mem_wen <= 1'b0;
            wb_rd   <= '0;
            wb_wen  <= 1'b0;
        end else begin
            mem_rd  <= ex_rd;
            mem_wen <= ex_wen;
            wb_rd   <= mem_rd;
            wb_wen  <= mem_wen;
        end
    end

    // newest matching producer wins
    function automatic rvfwd_pkg::fwd_src_e pick_src(
        input logic [`RV_REG_ADDR_W-1:0] addr
    );
        rvfwd_pkg::fwd_src_e src;
        if (addr == '0) begin
            src = rvfwd_pkg::FWD_RF; // x0 never forwarded
        end else if (ex_wen && (ex_rd == addr)) begin
            src = rvfwd_pkg::FWD_EX;
        end else if (mem_wen && (mem_rd == addr)) begin
            src = rvfwd_pkg::FWD_MEM;
        end else if (wb_wen && (wb_rd == addr)) begin
            src = rvfwd_pkg::FWD_WB;
        end else begin
            src = rvfwd_pkg::FWD_RF;
        end
        return src;
    endfunction

    always_comb begin
        rs1_src = pick_src(rs1_addr);
        rs2_src = pick_src(rs2_addr);
    end

    assign rf_we    = wb_wen && (wb_rd != '0);
    assign rf_waddr = wb_rd;
    assign rf_wdata = wb_result;

    // a live in-flight producer must not be bypassed by the register file read
    property p_no_stale_read(addr, src);
        @(posedge clk) disable iff (!rst_n)
        ((addr != '0) && ((ex_wen && (ex_rd == addr)) || (mem_wen && (mem_rd == addr)) ||
                          (wb_wen && (wb_rd == addr))))
        |-> (src != rvfwd_pkg::FWD_RF);
    endproperty

    a_rs1_fwd: assert property (p_no_stale_read(rs1_addr, rs1_src))
        else $error("rs1 read from register file with a pending producer");
    a_rs2_fwd: assert property (p_no_stale_read(rs2_addr, rs2_src))
        else $error("rs2 read from register file with a pending producer");

endmodule

`default_nettype wire

// File: src/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvfwd_config.svh"

module operand_forward (
    input  rvfwd_pkg::fwd_src_e        rs1_src,
    input  rvfwd_pkg::fwd_src_e        rs2_src,
    input  wire  [`RV_XLEN-1:0]        rf_rdata1,
    input  wire  [`RV_XLEN-1:0]        rf_rdata2,
    input  wire  [`RV_XLEN-1:0]        ex_result,
    input  rvfwd_pkg::ext_mode_e       ex_ext,
    input  wire  [`RV_XLEN-1:0]        mem_result,
    input  wire  [`RV_XLEN-1:0]        wb_result,
    output logic [`RV_XLEN-1:0]        rs1_data,
    output logic [`RV_XLEN-1:0]        rs2_data
);

    logic [`RV_XLEN-1:0] ex_val;

    // ex result is not yet widened, do it here once for both operands
    always_comb begin
        case (ex_ext)
            rvfwd_pkg::EXT_NONE: begin
                ex_val = ex_result;
            end
            rvfwd_pkg::EXT_WORD_S: begin
                ex_val = {{(`RV_XLEN-32){ex_result[31]}}, ex_result[31:0]};
            end
            rvfwd_pkg::EXT_WORD_Z: begin
                ex_val = {{(`RV_XLEN-32){1'b0}}, ex_result[31:0]};
            end
            rvfwd_pkg::EXT_HALF_S: begin
                ex_val = {{(`RV_XLEN-16){ex_result[15]}}, ex_result[15:0]};
            end
            default: begin
                ex_val = ex_result;
            end
        endcase
    end

    // four-way select per operand
    function automatic logic [`RV_XLEN-1:0] pick_val(
        input rvfwd_pkg::fwd_src_e src,
        input logic [`RV_XLEN-1:0] rf_val,
        input logic [`RV_XLEN-1:0] ex_v,
        input logic [`RV_XLEN-1:0] mem_v,
        input logic [`RV_XLEN-1:0] wb_v
    );
        logic [`RV_XLEN-1:0] val;
        case (src)
            rvfwd_pkg::FWD_EX: begin
                val = ex_v;
            end
            rvfwd_pkg::FWD_MEM: begin
                val = mem_v;
            end
            rvfwd_pkg::FWD_WB: begin
                val = wb_v; // covers the rf write cycle too
            end
            default: begin
                val = rf_val;
            end
        endcase
        return val;
    endfunction

    always_comb begin
        rs1_data = pick_val(rs1_src, rf_rdata1, ex_val, mem_result, wb_result);
        rs2_data = pick_val(rs2_src, rf_rdata2, ex_val, mem_result, wb_result);
    end

endmodule

`default_nettype wire

// File: src/operand_read_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvfwd_config.svh"

module operand_read_top (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`RV_REG_ADDR_W-1:0]  rs1_addr,
    input  wire  [`RV_REG_ADDR_W-1:0]  rs2_addr,
    input  wire  [`RV_REG_ADDR_W-1:0]  ex_rd,
    input  wire                        ex_wen,
    input  wire  [`RV_XLEN-1:0]        ex_result,
    input  rvfwd_pkg::ext_mode_e       ex_ext,
    input  wire  [`RV_XLEN-1:0]        mem_result,
    input  wire  [`RV_XLEN-1:0]        wb_result,
    output logic [`RV_XLEN-1:0]        rs1_data,
    output logic [`RV_XLEN-1:0]        rs2_data
);

    rvfwd_pkg::fwd_src_e       rs1_src;
    rvfwd_pkg::fwd_src_e       rs2_src;
    logic                      rf_we;
    logic [`RV_REG_ADDR_W-1:0] rf_waddr;
    logic [`RV_XLEN-1:0]       rf_wdata;
    logic [`RV_XLEN-1:0]       rf_rdata1;
    logic [`RV_XLEN-1:0]       rf_rdata2;

    hazard_track hazard_track_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .ex_rd    (ex_rd),
        .ex_wen   (ex_wen),
        .wb_result(wb_result),
        .rs1_src  (rs1_src),
        .rs2_src  (rs2_src),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    reg_file reg_file_i (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr1(rs1_addr),
        .raddr2(rs2_addr),
        .rdata1(rf_rdata1),
        .rdata2(rf_rdata2),
        .we    (rf_we),
        .waddr (rf_waddr),
        .wdata (rf_wdata)
    );

    operand_forward operand_forward_i (
        .rs1_src   (rs1_src),
        .rs2_src   (rs2_src),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .ex_result (ex_result),
        .ex_ext    (ex_ext),
        .mem_result(mem_result),
        .wb_result (wb_result),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data)
    );

endmodule

`default_nettype wire

// File: src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvfwd_config.svh"

module reg_file (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire  [`RV_REG_ADDR_W-1:0]  raddr1,
    input  wire  [`RV_REG_ADDR_W-1:0]  raddr2,
    output logic [`RV_XLEN-1:0]        rdata1,
    output logic [`RV_XLEN-1:0]        rdata2,
    input  wire                        we,
    input  wire  [`RV_REG_ADDR_W-1:0]  waddr,
    input  wire  [`RV_XLEN-1:0]        wdata
);

    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin // x0 is hardwired
            regs[waddr] <= wdata;
        end
    end

    // old value in the write cycle, wb bypass covers it
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // x0 reads zero on both ports
    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        ((raddr1 != '0) || (rdata1 == '0)) && ((raddr2 != '0) || (rdata2 == '0))
    ) else $error("x0 read back a nonzero value");

endmodule

`default_nettype wire

// File: src/rvfwd_pkg.sv
`default_nettype none

package rvfwd_pkg;

    // how the ex result is widened before it is forwarded
    typedef enum logic [1:0] {
        EXT_NONE   = 2'd0, // full 64-bit value
        EXT_WORD_S = 2'd1, // lw, addw and friends
        EXT_WORD_Z = 2'd2, // lwu
        EXT_HALF_S = 2'd3  // lh
    } ext_mode_e;

    // where an operand comes from, newest producer first
    typedef enum logic [1:0] {
        FWD_RF  = 2'd0,
        FWD_EX  = 2'd1,
        FWD_MEM = 2'd2,
        FWD_WB  = 2'd3
    } fwd_src_e;

endpackage

`default_nettype wire

// File: verilog.f
+incdir+include
src/rvfwd_pkg.sv
src/reg_file.sv
src/hazard_track.sv
src/operand_forward.sv
src/operand_read_top.sv
dv/operand_read_tb.sv
